// ==== rtl/memacc_types_pkg.sv ====
// Memory access stage types
`default_nettype none

package memacc_types_pkg;

    localparam int ADDR_W     = 64;
    localparam int DATA_W     = 64;
    localparam int STRB_W     = DATA_W / 8;
    localparam int REG_ADDR_W = 6;
    localparam int REG_TAG_W  = 3;

    typedef logic [ADDR_W-1:0]     addr_t;       // Byte address
    typedef logic [DATA_W-1:0]     dword_t;      // One 8-byte data word
    typedef logic [STRB_W-1:0]     strb_t;       // One bit per byte lane
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;   // Zero means no register write
    typedef logic [REG_TAG_W-1:0]  reg_tag_t;    // Writeback tag

    // Encoded access size
    typedef enum logic [1:0] {
        MEMOP_1B = 2'd0,
        MEMOP_2B = 2'd1,
        MEMOP_4B = 2'd2,
        MEMOP_8B = 2'd3
    } memop_size_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_ACCEPT,
        ST_WAIT_RESP,
        ST_HOLD
    } access_state_e;

endpackage

`default_nettype wire

// ==== rtl/memacc_bus_pkg.sv ====
// Memory access stage buses
`default_nettype none

package memacc_bus_pkg;

    import memacc_types_pkg::*;

    // Operation as it arrives from execute
    typedef struct packed {
        logic        store;
        logic        sign_ext;
        memop_size_e size;
        addr_t       addr;
        dword_t      wdata;
        reg_addr_t   reg_addr;
        reg_tag_t    reg_tag;
    } memop_req_t;

    // Queue entry with store data already spread over the lanes
    typedef struct packed {
        logic        store;
        logic        sign_ext;
        memop_size_e size;
        addr_t       addr;
        dword_t      lane_wdata;
        strb_t       wstrb;
        logic        wena;            // Load with a real destination register
        reg_addr_t   reg_addr;
        reg_tag_t    reg_tag;
    } memop_entry_t;

    typedef struct packed {
        logic        store;
        memop_size_e size;
        addr_t       addr;
        dword_t      wdata;
        strb_t       wstrb;
    } mem_req_t;

    typedef struct packed {
        reg_addr_t waddr;
        dword_t    wdata;
        reg_tag_t  wtag;
    } wb_t;

endpackage

`default_nettype wire

// ==== rtl/memop_queue.sv ====
// Memory operation FIFO
`timescale 1ns/1ps
`default_nettype none

module memop_queue import memacc_bus_pkg::*; #(
    parameter int QUEUE_ABITS = 2
) (
    input  logic         i_clk,
    input  logic         i_nrst,
    input  logic         i_we,
    input  logic         i_re,
    input  memop_entry_t i_wdata,
    output memop_entry_t o_rdata,
    output logic         o_full,
    output logic         o_nempty
);

    localparam int DEPTH = 2 ** QUEUE_ABITS;

    memop_entry_t           mem_q [DEPTH];
    logic [QUEUE_ABITS-1:0] wr_ptr;
    logic [QUEUE_ABITS-1:0] rd_ptr;
    logic [QUEUE_ABITS:0]   count;              // Holds 0 up to DEPTH
    logic                   do_wr;
    logic                   do_rd;

    assign do_wr = i_we && !o_full;             // Write while full is dropped
    assign do_rd = i_re && o_nempty;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1; // Pointers wrap on their own
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_wr) mem_q[wr_ptr] <= i_wdata;
    end

    assign o_rdata  = mem_q[rd_ptr];            // Head is visible without a read
    assign o_full   = count[QUEUE_ABITS];       // Top bit set only at DEPTH
    assign o_nempty = |count;

endmodule

`default_nettype wire

// ==== rtl/memop_decode.sv ====
// Memory operation encoder
`timescale 1ns/1ps
`default_nettype none

module memop_decode import memacc_types_pkg::*, memacc_bus_pkg::*; (
    input  memop_req_t   i_req,
    output memop_entry_t o_entry
);

    dword_t lane_wdata;
    strb_t  size_strb;

    // Spread the low bytes over every lane and place the strobes
    always_comb begin
        case (i_req.size)
            MEMOP_1B: begin
                lane_wdata = {8{i_req.wdata[7:0]}};
                size_strb  = 8'h01 << i_req.addr[2:0];
            end
            MEMOP_2B: begin
                lane_wdata = {4{i_req.wdata[15:0]}};
                size_strb  = 8'h03 << {i_req.addr[2:1], 1'b0};
            end
            MEMOP_4B: begin
                lane_wdata = {2{i_req.wdata[31:0]}};
                size_strb  = 8'h0f << {i_req.addr[2], 2'b00};
            end
            default: begin
                lane_wdata = i_req.wdata;
                size_strb  = 8'hff;
            end
        endcase
    end

    always_comb begin
        o_entry.store      = i_req.store;
        o_entry.sign_ext   = i_req.sign_ext;
        o_entry.size       = i_req.size;
        o_entry.addr       = i_req.addr;
        o_entry.lane_wdata = lane_wdata;
        o_entry.wstrb      = i_req.store ? size_strb : '0;  // Loads write no bytes
        // Stores and loads to x0 never reach the register file
        o_entry.wena       = !i_req.store && (i_req.reg_addr != '0);
        o_entry.reg_addr   = i_req.reg_addr;
        o_entry.reg_tag    = i_req.reg_tag;
    end

endmodule

`default_nettype wire

// ==== rtl/memop_execute.sv ====
// Memory access sequencer
`timescale 1ns/1ps
`default_nettype none

module memop_execute import memacc_types_pkg::*, memacc_bus_pkg::*; (
    input  logic         i_clk,
    input  logic         i_nrst,
    input  memop_entry_t i_head,
    input  logic         i_nempty,
    output logic         o_pop,
    output logic         o_mem_valid,
    output mem_req_t     o_mem_req,
    input  logic         i_mem_req_ready,
    input  logic         i_mem_data_valid,
    input  logic         i_wb_ready,
    output logic         o_wb_wena,
    output reg_addr_t    o_wb_waddr,
    output reg_tag_t     o_wb_wtag,
    output memop_entry_t o_cur,
    output logic         o_capture,
    output logic         o_use_hold,
    output logic         o_valid,
    output logic         o_idle
);

    access_state_e state;
    access_state_e state_nxt;
    memop_entry_t  cur_q;                        // Operation in flight
    memop_entry_t  src;
    logic          issue;

    always_comb begin
        state_nxt   = state;
        issue       = 1'b0;
        o_mem_valid = 1'b0;
        o_wb_wena   = 1'b0;
        o_capture   = 1'b0;
        o_use_hold  = 1'b0;
        o_valid     = 1'b0;
        case (state)
            ST_IDLE: begin
                issue = i_nempty;
            end
            ST_WAIT_ACCEPT: begin
                o_mem_valid = 1'b1;              // Replay the registered request
                if (i_mem_req_ready) state_nxt = ST_WAIT_RESP;
            end
            ST_WAIT_RESP: begin
                if (i_mem_data_valid) begin
                    o_wb_wena = cur_q.wena;
                    if (cur_q.wena && !i_wb_ready) begin
                        o_capture = 1'b1;        // Park the load result
                        state_nxt = ST_HOLD;
                    end else begin
                        o_valid   = 1'b1;
                        issue     = i_nempty;
                        state_nxt = ST_IDLE;
                    end
                end
            end
            ST_HOLD: begin
                o_wb_wena  = 1'b1;
                o_use_hold = 1'b1;
                if (i_wb_ready) begin
                    o_valid   = 1'b1;
                    issue     = i_nempty;
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase

        // Next request leaves in the same cycle as the completion
        if (issue) begin
            o_mem_valid = 1'b1;
            state_nxt   = i_mem_req_ready ? ST_WAIT_RESP : ST_WAIT_ACCEPT;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) state <= ST_IDLE;
        else         state <= state_nxt;
    end

    always_ff @(posedge i_clk) begin
        if (issue) cur_q <= i_head;
    end

    assign src   = issue ? i_head : cur_q;       // Head only on the issue cycle
    assign o_pop = issue;

    always_comb begin
        o_mem_req.store = src.store;
        o_mem_req.size  = src.size;
        o_mem_req.addr  = src.addr;
        o_mem_req.wdata = src.lane_wdata;
        o_mem_req.wstrb = src.wstrb;
    end

    assign o_wb_waddr = cur_q.reg_addr;
    assign o_wb_wtag  = cur_q.reg_tag;
    assign o_cur      = cur_q;
    assign o_idle     = (state == ST_IDLE) && !i_nempty;

endmodule

`default_nettype wire

// ==== rtl/load_result.sv ====
// Load data aligner
`timescale 1ns/1ps
`default_nettype none

module load_result import memacc_types_pkg::*, memacc_bus_pkg::*; (
    input  logic         i_clk,
    input  logic         i_nrst,
    input  memop_entry_t i_cur,
    input  dword_t       i_mem_data,
    input  logic         i_capture,
    input  logic         i_use_hold,
    output dword_t       o_wdata
);

    dword_t shifted;
    dword_t size_mask;
    dword_t result;
    dword_t hold_q;
    logic   sign_bit;

    // Move the addressed byte down to lane 0
    assign shifted = i_mem_data >> {i_cur.addr[2:0], 3'b000};

    always_comb begin
        case (i_cur.size)
            MEMOP_1B: begin
                size_mask = 64'h0000_0000_0000_00ff;
                sign_bit  = shifted[7];
            end
            MEMOP_2B: begin
                size_mask = 64'h0000_0000_0000_ffff;
                sign_bit  = shifted[15];
            end
            MEMOP_4B: begin
                size_mask = 64'h0000_0000_ffff_ffff;
                sign_bit  = shifted[31];
            end
            default: begin
                size_mask = '1;
                sign_bit  = shifted[63];     // Full word needs no extension
            end
        endcase
        result = (shifted & size_mask) | ((i_cur.sign_ext && sign_bit) ? ~size_mask : '0);
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst)        hold_q <= '0;
        else if (i_capture) hold_q <= result;
    end

    assign o_wdata = i_use_hold ? hold_q : result;  // Cache data is gone during a stall

endmodule

`default_nettype wire

// ==== rtl/mem_access.sv ====
// Memory access stage
`timescale 1ns/1ps
`default_nettype none

module mem_access import memacc_types_pkg::*, memacc_bus_pkg::*; #(
    parameter int QUEUE_ABITS = 2
) (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_memop_valid,
    input  memop_req_t i_memop,
    output logic       o_memop_ready,
    output logic       o_mem_valid,
    output mem_req_t   o_mem_req,
    input  logic       i_mem_req_ready,
    input  logic       i_mem_data_valid,
    input  dword_t     i_mem_data,
    output logic       o_mem_resp_ready,
    output logic       o_wb_wena,
    output wb_t        o_wb,
    input  logic       i_wb_ready,
    output logic       o_valid,
    output logic       o_idle
);

    memop_entry_t new_entry;
    memop_entry_t head;
    memop_entry_t cur;
    logic         queue_full;
    logic         queue_nempty;
    logic         queue_we;
    logic         pop;
    logic         capture;
    logic         use_hold;
    reg_addr_t    wb_waddr;
    reg_tag_t     wb_wtag;
    dword_t       wb_wdata;

    assign queue_we         = i_memop_valid && !queue_full;
    assign o_memop_ready    = !queue_full;
    assign o_mem_resp_ready = 1'b1;              // Responses are never refused
    assign o_wb             = '{waddr: wb_waddr, wdata: wb_wdata, wtag: wb_wtag};

    memop_decode u_decode (.i_req(i_memop), .o_entry(new_entry));

    memop_queue #(.QUEUE_ABITS(QUEUE_ABITS)) u_queue (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_we(queue_we), .i_re(pop), .i_wdata(new_entry),
        .o_rdata(head), .o_full(queue_full), .o_nempty(queue_nempty)
    );

    memop_execute u_execute (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_head(head), .i_nempty(queue_nempty), .o_pop(pop),
        .o_mem_valid(o_mem_valid), .o_mem_req(o_mem_req),
        .i_mem_req_ready(i_mem_req_ready), .i_mem_data_valid(i_mem_data_valid),
        .i_wb_ready(i_wb_ready), .o_wb_wena(o_wb_wena),
        .o_wb_waddr(wb_waddr), .o_wb_wtag(wb_wtag),
        .o_cur(cur), .o_capture(capture), .o_use_hold(use_hold),
        .o_valid(o_valid), .o_idle(o_idle)
    );

    load_result u_result (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_cur(cur), .i_mem_data(i_mem_data),
        .i_capture(capture), .i_use_hold(use_hold),
        .o_wdata(wb_wdata)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clkgen.sv ====
// Clock and reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_nrst
);

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;              // 10 ns period
    end

    initial begin
        o_nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_nrst = 1'b1;                          // Release away from the rising edge
    end

endmodule

`default_nettype wire

// ==== tb/tb_mem_access.sv ====
// Memory access stage testbench
`timescale 1ns/1ps
`default_nettype none

module tb_mem_access import memacc_types_pkg::*, memacc_bus_pkg::*; ();

    localparam int    QUEUE_ABITS = 2;
    localparam int    DEPTH       = 2 ** QUEUE_ABITS;
    localparam int    NUM_OPS     = 400;
    localparam int    MAX_CYCLES  = NUM_OPS * 20 + 100;
    localparam addr_t BASE        = 64'h1000;

    logic       i_clk;
    logic       i_nrst;
    logic       i_memop_valid;
    memop_req_t i_memop;
    logic       o_memop_ready;
    logic       o_mem_valid;
    mem_req_t   o_mem_req;
    logic       i_mem_req_ready;
    logic       i_mem_data_valid;
    dword_t     i_mem_data;
    logic       o_mem_resp_ready;
    logic       o_wb_wena;
    wb_t        o_wb;
    logic       i_wb_ready;
    logic       o_valid;
    logic       o_idle;

    dword_t     mem_model [addr_t];             // Cache contents by word address
    memop_req_t pending [$];                    // Accepted but not yet sent to the cache
    memop_req_t cur_op;                         // Operation the cache is serving
    dword_t     exp_wdata;
    wb_t        prev_wb;
    logic       holding;
    logic       resp_pend;
    logic       op_taken;
    int         acc_delay = 0;
    int         resp_cnt = 0;
    int         sent = 0;
    int         accepted = 0;
    int         completed = 0;
    int         cycles = 0;

    tb_clkgen u_clkgen (.o_clk(i_clk), .o_nrst(i_nrst));

    mem_access #(.QUEUE_ABITS(QUEUE_ABITS)) u_dut (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_memop_valid(i_memop_valid), .i_memop(i_memop), .o_memop_ready(o_memop_ready),
        .o_mem_valid(o_mem_valid), .o_mem_req(o_mem_req), .i_mem_req_ready(i_mem_req_ready),
        .i_mem_data_valid(i_mem_data_valid), .i_mem_data(i_mem_data),
        .o_mem_resp_ready(o_mem_resp_ready), .o_wb_wena(o_wb_wena), .o_wb(o_wb),
        .i_wb_ready(i_wb_ready), .o_valid(o_valid), .o_idle(o_idle)
    );

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected)
            stop_with_error($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                      $time, name, actual, expected));
    endtask

    function automatic dword_t read_word(addr_t addr);
        addr_t key;
        key = {addr[63:3], 3'b000};
        return mem_model.exists(key) ? mem_model[key] : '0;     // Unwritten words read 0
    endfunction

    function automatic dword_t replicate(dword_t data, memop_size_e size);
        dword_t r;
        int     n;
        int     i;
        n = 1 << size;
        for (i = 0; i < 8; i++) r[i*8 +: 8] = data[(i % n)*8 +: 8];
        return r;
    endfunction

    function automatic strb_t strobes(logic [2:0] off, memop_size_e size);
        strb_t s;
        int    i;
        for (i = 0; i < 8; i++)
            s[i] = (i >= int'(off)) && (i < int'(off) + (1 << size));
        return s;
    endfunction

    function automatic dword_t extend_load(dword_t word, logic [2:0] off,
                                           memop_size_e size, logic sign_ext);
        dword_t sh;
        dword_t r;
        sh = word >> (8 * int'(off));
        case (size)
            MEMOP_1B: r = {{56{sign_ext & sh[7]}}, sh[7:0]};
            MEMOP_2B: r = {{48{sign_ext & sh[15]}}, sh[15:0]};
            MEMOP_4B: r = {{32{sign_ext & sh[31]}}, sh[31:0]};
            default:  r = sh;
        endcase
        return r;
    endfunction

    task automatic new_operation();
        logic [2:0] off;
        i_memop.store    = $urandom_range(99) < 40;
        i_memop.sign_ext = 1'($urandom_range(1));
        i_memop.size     = memop_size_e'(2'($urandom_range(3)));
        off              = 3'(($urandom_range(7) >> i_memop.size) << i_memop.size);
        i_memop.addr     = BASE + 64'($urandom_range(31) * 8) + 64'(off);
        i_memop.wdata    = {$urandom, $urandom};
        i_memop.reg_addr = reg_addr_t'($urandom_range(63));
        i_memop.reg_tag  = reg_tag_t'($urandom_range(7));
        i_memop_valid    = 1'b1;
        sent++;
    endtask

    // Falling edge side of the cache, writeback and source models
    task automatic drive_inputs();
        if (op_taken) i_memop_valid = 1'b0;
        op_taken = 1'b0;
        if (!i_memop_valid && sent < NUM_OPS && $urandom_range(99) < 75) new_operation();
        i_mem_req_ready = (acc_delay == 0);
        if (resp_pend && resp_cnt > 0) resp_cnt--;
        i_mem_data_valid = resp_pend && (resp_cnt == 0);
        i_mem_data = i_mem_data_valid ? read_word(cur_op.addr) : {$urandom, $urandom};
        i_wb_ready = $urandom_range(99) < 60;
    endtask

    // Runs on the rising edge before the DUT registers update
    task automatic observe_cycle();
        logic   resp_now;
        logic   wb_op;
        logic   exp_wena;
        logic   exp_valid;
        dword_t word;
        dword_t sdata;
        strb_t  sstrb;
        int     i;
        if (accepted - completed < DEPTH)
            check_value("o_memop_ready", 64'(o_memop_ready), 64'(1));
        resp_now  = resp_pend && i_mem_data_valid;
        wb_op     = !cur_op.store && (cur_op.reg_addr != '0);
        exp_wena  = (resp_now && wb_op) || holding;
        exp_valid = (resp_now && (!wb_op || i_wb_ready)) || (holding && i_wb_ready);
        if (resp_now)
            exp_wdata = extend_load(read_word(cur_op.addr), cur_op.addr[2:0],
                                    cur_op.size, cur_op.sign_ext);
        if (resp_now)
            check_value("o_mem_resp_ready", 64'(o_mem_resp_ready), 64'(1));
        check_value("o_wb_wena", 64'(o_wb_wena), 64'(exp_wena));
        check_value("o_valid", 64'(o_valid), 64'(exp_valid));
        if (exp_wena) begin
            check_value("o_wb.waddr", 64'(o_wb.waddr), 64'(cur_op.reg_addr));
            check_value("o_wb.wtag", 64'(o_wb.wtag), 64'(cur_op.reg_tag));
            check_value("o_wb.wdata", o_wb.wdata, exp_wdata);
        end
        if (holding) check_value("o_wb changed in stall", 64'(o_wb != prev_wb), 64'(0));
        if (resp_now) resp_pend = 1'b0;
        holding = exp_wena && !i_wb_ready;
        prev_wb = o_wb;
        if (exp_valid) completed++;
        if (o_mem_valid && i_mem_req_ready) begin
            if (pending.size() == 0) begin
                stop_with_error("Cache request issued with no operation waiting");
            end else if (resp_pend) begin
                stop_with_error("Cache request issued while a response is still outstanding");
            end else begin
                cur_op = pending.pop_front();
                check_value("o_mem_req.store", 64'(o_mem_req.store), 64'(cur_op.store));
                check_value("o_mem_req.size", 64'(o_mem_req.size), 64'(cur_op.size));
                check_value("o_mem_req.addr", o_mem_req.addr, cur_op.addr);
                if (cur_op.store) begin
                    sdata = replicate(cur_op.wdata, cur_op.size);
                    sstrb = strobes(cur_op.addr[2:0], cur_op.size);
                    check_value("o_mem_req.wdata", o_mem_req.wdata, sdata);
                    check_value("o_mem_req.wstrb", 64'(o_mem_req.wstrb), 64'(sstrb));
                    word = read_word(cur_op.addr);
                    for (i = 0; i < 8; i++) if (sstrb[i]) word[i*8 +: 8] = sdata[i*8 +: 8];
                    mem_model[{cur_op.addr[63:3], 3'b000}] = word;
                end
                acc_delay = $urandom_range(3);
                resp_cnt  = $urandom_range(3, 1);
                resp_pend = 1'b1;
            end
        end else if (o_mem_valid) begin
            acc_delay--;                        // Cache still busy with the accept
        end
        if (i_memop_valid && o_memop_ready) begin
            pending.push_back(i_memop);
            accepted++;
            op_taken = 1'b1;
        end
    endtask

    always @(posedge i_clk) begin
        cycles++;
        if (cycles > MAX_CYCLES)
            stop_with_error($sformatf("Timeout: run did not finish in %0d cycles", MAX_CYCLES));
    end

    initial begin
        void'($urandom(5));
        i_memop_valid    = 1'b0;
        i_memop          = '0;
        i_mem_req_ready  = 1'b0;
        i_mem_data_valid = 1'b0;
        i_mem_data       = '0;
        i_wb_ready       = 1'b0;
        cur_op           = '0;
        prev_wb          = '0;
        exp_wdata        = '0;
        holding          = 1'b0;
        resp_pend        = 1'b0;
        op_taken         = 1'b0;
        wait (i_nrst === 1'b1);
        @(negedge i_clk);
        check_value("o_mem_valid", 64'(o_mem_valid), 64'(0));
        check_value("o_wb_wena", 64'(o_wb_wena), 64'(0));
        check_value("o_valid", 64'(o_valid), 64'(0));
        check_value("o_memop_ready", 64'(o_memop_ready), 64'(1));
        check_value("o_idle", 64'(o_idle), 64'(1));
        while (completed < NUM_OPS) begin
            drive_inputs();
            @(posedge i_clk);
            observe_cycle();
            @(negedge i_clk);
        end
        check_value("o_idle", 64'(o_idle), 64'(1));
        check_value("operations left", 64'(pending.size()), 64'(0));
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/memacc_types_pkg.sv
rtl/memacc_bus_pkg.sv
rtl/memop_queue.sv
rtl/memop_decode.sv
rtl/memop_execute.sv
rtl/load_result.sv
rtl/mem_access.sv
tb/tb_clkgen.sv
tb/tb_mem_access.sv

// ==== Makefile ====
TOP = tb_mem_access

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f all.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: lint sim clean
